// ==== src/hpsdr_proto_pkg.sv ====
// hpsdr protocol-1 framing constants, stream types and downstream payload structs
`default_nettype none

package hpsdr_proto_pkg;

  typedef logic [7:0]  eth_byte_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] sample_t;

  localparam udp_port_t DATA_PORT     = 16'd1024;
  localparam eth_byte_t PREAMBLE_0    = 8'hef;
  localparam eth_byte_t PREAMBLE_1    = 8'hfe;
  localparam eth_byte_t CMD_EP_DATA   = 8'h01;
  localparam eth_byte_t CMD_DISCOVERY = 8'h02;
  localparam eth_byte_t CMD_RUNSTOP   = 8'h04;
  localparam eth_byte_t EP_TX         = 8'h02;
  localparam eth_byte_t SYNC_BYTE     = 8'h7f;
  localparam int        PAYLOAD_BYTES = 1024;
  localparam int        BLOCK_BYTES   = 512;

  typedef enum logic [3:0] {
    START, PREAMBLE, DECODE, RUNSTOP, DISCOVERY, ENDPOINT,
    SEQNO1, SEQNO2, SEQNO3, SEQNO4, FRAMES
  } ds_state_e;

  typedef struct packed {
    eth_byte_t data;
    logic      valid;
    logic      first;  // set on payload byte 0 only
  } payload_beat_t;

  typedef struct packed {
    eth_byte_t c0;
    eth_byte_t c1;
    eth_byte_t c2;
    eth_byte_t c3;
    eth_byte_t c4;
  } cc_frame_t;

  typedef struct packed {
    sample_t left;
    sample_t right;
    sample_t i;
    sample_t q;
  } tx_sample_t;

endpackage

`default_nettype wire

// ==== src/radio_cfg_pkg.sv ====
// radio configuration register map and settings struct written by command frames
`default_nettype none

package radio_cfg_pkg;

  typedef logic [6:0]  cc_addr_t;
  typedef logic [31:0] freq_t;
  typedef logic [1:0]  rate_t;
  typedef logic [2:0]  nrx_t;

  localparam cc_addr_t ADDR_GENERAL  = 7'd0;
  localparam cc_addr_t ADDR_TX_FREQ  = 7'd1;
  localparam cc_addr_t ADDR_RX1_FREQ = 7'd2;

  typedef struct packed {
    logic  mox;
    rate_t rate;
    nrx_t  nrx;  // number of receivers minus one
    freq_t tx_freq;
    freq_t rx1_freq;
  } radio_cfg_t;

endpackage

`default_nettype wire

// ==== src/ds_unpacker.sv ====
// downstream packet decoder: preamble and command matching, run control and payload beats
`timescale 1ns/1ps
`default_nettype none

module ds_unpacker (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire hpsdr_proto_pkg::udp_port_t eth_port,
  input  wire                            eth_broadcast,
  input  wire                            eth_valid,
  input  wire hpsdr_proto_pkg::eth_byte_t eth_data,
  input  wire                            eth_unreachable,
  output logic                           metis_discovery,
  output logic                           run,
  output logic                           wide_spectrum,
  output hpsdr_proto_pkg::payload_beat_t beat
);

  hpsdr_proto_pkg::ds_state_e state;
  hpsdr_proto_pkg::ds_state_e state_next;

  logic [$clog2(hpsdr_proto_pkg::PAYLOAD_BYTES)-1:0] count;
  logic [$clog2(hpsdr_proto_pkg::PAYLOAD_BYTES)-1:0] count_next;

  logic run_next;
  logic wide_spectrum_next;
  logic on_port;

  assign on_port = (eth_port == hpsdr_proto_pkg::DATA_PORT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= hpsdr_proto_pkg::START;
      count         <= '0;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (eth_unreachable) begin
      state         <= hpsdr_proto_pkg::START;  // host gone, stop streaming
      count         <= '0;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (!eth_valid) begin
      state <= hpsdr_proto_pkg::START;
      count <= '0;
    end else begin
      state         <= state_next;
      count         <= count_next;
      run           <= run_next;
      wide_spectrum <= wide_spectrum_next;
    end
  end

  always_comb begin
    state_next         = hpsdr_proto_pkg::START;
    count_next         = '0;
    run_next           = run;
    wide_spectrum_next = wide_spectrum;
    metis_discovery    = 1'b0;
    beat.data          = eth_data;
    beat.valid         = 1'b0;
    beat.first         = 1'b0;

    case (state)
      hpsdr_proto_pkg::START: begin
        if (on_port && eth_data == hpsdr_proto_pkg::PREAMBLE_0) state_next = hpsdr_proto_pkg::PREAMBLE;
      end
      hpsdr_proto_pkg::PREAMBLE: begin
        if (on_port && eth_data == hpsdr_proto_pkg::PREAMBLE_1) state_next = hpsdr_proto_pkg::DECODE;
      end
      hpsdr_proto_pkg::DECODE: begin
        if (eth_data == hpsdr_proto_pkg::CMD_EP_DATA) begin
          state_next = hpsdr_proto_pkg::ENDPOINT;
        end else if (eth_data == hpsdr_proto_pkg::CMD_RUNSTOP) begin
          state_next = hpsdr_proto_pkg::RUNSTOP;
        end else if (eth_data == hpsdr_proto_pkg::CMD_DISCOVERY && eth_broadcast) begin
          state_next = hpsdr_proto_pkg::DISCOVERY;  // only a broadcast query gets an answer
        end
      end
      hpsdr_proto_pkg::RUNSTOP: begin
        run_next           = eth_data[0];
        wide_spectrum_next = eth_data[1];
      end
      hpsdr_proto_pkg::DISCOVERY: begin
        metis_discovery = eth_valid;
      end
      hpsdr_proto_pkg::ENDPOINT: begin
        if (eth_data == hpsdr_proto_pkg::EP_TX) state_next = hpsdr_proto_pkg::SEQNO1;
      end
      hpsdr_proto_pkg::SEQNO1: state_next = hpsdr_proto_pkg::SEQNO2;  // sequence number is not checked
      hpsdr_proto_pkg::SEQNO2: state_next = hpsdr_proto_pkg::SEQNO3;
      hpsdr_proto_pkg::SEQNO3: state_next = hpsdr_proto_pkg::SEQNO4;
      hpsdr_proto_pkg::SEQNO4: state_next = hpsdr_proto_pkg::FRAMES;
      hpsdr_proto_pkg::FRAMES: begin
        beat.valid = eth_valid;
        beat.first = eth_valid && (count == '0);
        count_next = count + 1'b1;
        if (!(&count)) state_next = hpsdr_proto_pkg::FRAMES;  // last payload byte ends the packet
      end
      default: begin
        state_next = hpsdr_proto_pkg::START;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/frame_parser.sv ====
// 512-byte block splitter: sync check, command frame capture and sample byte forwarding
`timescale 1ns/1ps
`default_nettype none

module frame_parser (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire hpsdr_proto_pkg::payload_beat_t beat,
  output hpsdr_proto_pkg::cc_frame_t         cc,
  output logic                               cc_valid,
  output logic                               sync_err,
  output logic                               block_start,
  output hpsdr_proto_pkg::eth_byte_t         sample_byte,
  output logic                               byte_valid
);

  logic [$clog2(hpsdr_proto_pkg::BLOCK_BYTES)-1:0] idx;
  logic [$clog2(hpsdr_proto_pkg::BLOCK_BYTES)-1:0] idx_cur;
  logic                                            sync_ok;
  logic                                            sync_match;

  assign idx_cur    = beat.first ? '0 : idx;  // payload start realigns the block
  assign sync_match = (beat.data == hpsdr_proto_pkg::SYNC_BYTE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx         <= '0;
      sync_ok     <= 1'b0;
      cc_valid    <= 1'b0;
      sync_err    <= 1'b0;
      block_start <= 1'b0;
      byte_valid  <= 1'b0;
    end else begin
      cc_valid    <= 1'b0;
      sync_err    <= 1'b0;
      block_start <= 1'b0;
      byte_valid  <= 1'b0;
      if (beat.valid) begin
        idx         <= idx_cur + 1'b1;  // wraps to zero after byte 511
        block_start <= (idx_cur == '0);
        if (idx_cur == '0) begin
          sync_ok <= sync_match;
        end else if (idx_cur < 9'd3) begin
          sync_ok <= sync_ok && sync_match;
        end
        if (idx_cur == 9'd2 && !(sync_ok && sync_match)) sync_err <= 1'b1;
        if (idx_cur == 9'd7 && sync_ok) cc_valid <= 1'b1;
        if (idx_cur >= 9'd8 && sync_ok) byte_valid <= 1'b1;  // a bad block stays silent
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat.valid) begin
      sample_byte <= beat.data;
      case (idx_cur)
        9'd3: cc.c0 <= beat.data;
        9'd4: cc.c1 <= beat.data;
        9'd5: cc.c2 <= beat.data;
        9'd6: cc.c3 <= beat.data;
        9'd7: cc.c4 <= beat.data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/cc_regs.sv ====
// command and control register block holding the radio settings
`timescale 1ns/1ps
`default_nettype none

module cc_regs (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire hpsdr_proto_pkg::cc_frame_t cc,
  input  wire                            cc_valid,
  output radio_cfg_pkg::radio_cfg_t      cfg
);

  radio_cfg_pkg::cc_addr_t addr;
  radio_cfg_pkg::freq_t    freq_word;

  assign addr      = cc.c0[7:1];
  assign freq_word = {cc.c1, cc.c2, cc.c3, cc.c4};  // big-endian, c1 is the top byte

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (cc_valid) begin
      cfg.mox <= cc.c0[0];  // every frame carries mox
      case (addr)
        radio_cfg_pkg::ADDR_GENERAL: begin
          cfg.rate <= cc.c1[1:0];
          cfg.nrx  <= cc.c4[5:3];
        end
        radio_cfg_pkg::ADDR_TX_FREQ: begin
          cfg.tx_freq <= freq_word;
        end
        radio_cfg_pkg::ADDR_RX1_FREQ: begin
          cfg.rx1_freq <= freq_word;
        end
        default: ;  // unused address leaves the settings alone
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/sample_assembler.sv ====
// collects eight sample bytes into one left/right/i/q transmit sample
`timescale 1ns/1ps
`default_nettype none

module sample_assembler (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            block_start,
  input  wire hpsdr_proto_pkg::eth_byte_t sample_byte,
  input  wire                            byte_valid,
  output hpsdr_proto_pkg::tx_sample_t    sample,
  output logic                           sample_valid
);

  logic [2:0]  count;
  logic [55:0] shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count        <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      if (block_start) begin
        count <= '0;  // each block starts on a sample boundary
      end else if (byte_valid) begin
        count        <= count + 1'b1;
        sample_valid <= (&count);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid) begin
      shift <= {shift[47:0], sample_byte};
      if (&count) sample <= {shift, sample_byte};  // left high byte arrived first
    end
  end

endmodule

`default_nettype wire

// ==== src/ds_top.sv ====
// downstream receive path of the radio card from udp payload to settings and tx samples
`timescale 1ns/1ps
`default_nettype none

module ds_top (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire hpsdr_proto_pkg::udp_port_t  eth_port,
  input  wire                             eth_broadcast,
  input  wire                             eth_valid,
  input  wire hpsdr_proto_pkg::eth_byte_t  eth_data,
  input  wire                             eth_unreachable,
  output logic                            metis_discovery,
  output logic                            run,
  output logic                            wide_spectrum,
  output logic                            sync_err,
  output radio_cfg_pkg::radio_cfg_t       cfg,
  output hpsdr_proto_pkg::tx_sample_t     sample,
  output logic                            sample_valid
);

  hpsdr_proto_pkg::payload_beat_t beat;
  hpsdr_proto_pkg::cc_frame_t     cc;
  hpsdr_proto_pkg::eth_byte_t     sample_byte;
  logic                           cc_valid;
  logic                           block_start;
  logic                           byte_valid;

  ds_unpacker i_unpacker (
    .clk             (clk),
    .rst_n           (rst_n),
    .eth_port        (eth_port),
    .eth_broadcast   (eth_broadcast),
    .eth_valid       (eth_valid),
    .eth_data        (eth_data),
    .eth_unreachable (eth_unreachable),
    .metis_discovery (metis_discovery),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .beat            (beat)
  );

  frame_parser i_parser (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat        (beat),
    .cc          (cc),
    .cc_valid    (cc_valid),
    .sync_err    (sync_err),
    .block_start (block_start),
    .sample_byte (sample_byte),
    .byte_valid  (byte_valid)
  );

  cc_regs i_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .cc       (cc),
    .cc_valid (cc_valid),
    .cfg      (cfg)
  );

  sample_assembler i_assembler (
    .clk          (clk),
    .rst_n        (rst_n),
    .block_start  (block_start),
    .sample_byte  (sample_byte),
    .byte_valid   (byte_valid),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

// ==== dv/tb_ds_top.sv ====
// testbench for the downstream receive path driven by packet records from a pattern file
`timescale 1ns/1ps
`default_nettype none

module tb_ds_top;

  localparam int WAIT_LIMIT = 2000;

  logic                        clk;
  logic                        rst_n;
  hpsdr_proto_pkg::udp_port_t  eth_port;
  logic                        eth_broadcast;
  logic                        eth_valid;
  hpsdr_proto_pkg::eth_byte_t  eth_data;
  logic                        eth_unreachable;
  logic                        metis_discovery;
  logic                        run;
  logic                        wide_spectrum;
  logic                        sync_err;
  radio_cfg_pkg::radio_cfg_t   cfg;
  hpsdr_proto_pkg::tx_sample_t sample;
  logic                        sample_valid;

  logic [7:0]  pkt [$];
  logic [63:0] exp_q [$];
  logic [7:0]  cc_bytes [0:9];
  integer      seed;
  int          nsamp;
  int          nsync;
  int          ndisc;

  ds_top i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .eth_port        (eth_port),
    .eth_broadcast   (eth_broadcast),
    .eth_valid       (eth_valid),
    .eth_data        (eth_data),
    .eth_unreachable (eth_unreachable),
    .metis_discovery (metis_discovery),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .sync_err        (sync_err),
    .cfg             (cfg),
    .sample          (sample),
    .sample_valid    (sample_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input logic [71:0] got, input logic [71:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // outputs are read at the falling edge before the inputs change
  task automatic observe();
    if (sample_valid) begin
      if (exp_q.size() == 0) begin
        $display("a sample came out although none was expected");
        stop_run();
      end else begin
        check({8'h0, sample}, {8'h0, exp_q.pop_front()}, "tx sample");
        nsamp++;
      end
    end
    if (sync_err) nsync++;
    if (metis_discovery) ndisc++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    observe();
    eth_valid       = 1'b0;
    eth_data        = 8'h00;
    eth_unreachable = 1'b0;
  endtask

  task automatic stream_packet(input logic [15:0] port, input logic bcast);
    foreach (pkt[k]) begin
      @(negedge clk);
      observe();
      eth_port      = port;
      eth_broadcast = bcast;
      eth_valid     = 1'b1;
      eth_data      = pkt[k];
    end
    idle_cycle();
  endtask

  task automatic pulse_unreachable();
    @(negedge clk);
    observe();
    eth_unreachable = 1'b1;
    idle_cycle();
  endtask

  // kind 0 run/stop, 1 discovery, 2 data, 3 data with a bad sync in block 0
  task automatic build_packet(input int kind, input logic [7:0] arg);
    int         rnd;
    logic [7:0] b;
    logic [63:0] s;
    logic       good;
    pkt = {};
    pkt.push_back(8'hef);
    pkt.push_back(8'hfe);
    if (kind == 0 || kind == 1) begin
      pkt.push_back(kind == 0 ? 8'h04 : 8'h02);
      pkt.push_back(arg);
      while (pkt.size() < 60) pkt.push_back(8'h00);
    end else begin
      pkt.push_back(8'h01);
      pkt.push_back(arg);
      for (int k = 0; k < 4; k++) pkt.push_back(8'(k));  // sequence number
      for (int blk = 0; blk < 2; blk++) begin
        good = (arg == 8'h02) && !(kind == 3 && blk == 0);
        pkt.push_back(8'h7f);
        pkt.push_back((kind == 3 && blk == 0) ? 8'h7e : 8'h7f);
        pkt.push_back(8'h7f);
        for (int k = 0; k < 5; k++) pkt.push_back(cc_bytes[blk * 5 + k]);
        for (int n = 0; n < 63; n++) begin
          s = '0;
          for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            b   = rnd[7:0];
            s   = {s[55:0], b};
            pkt.push_back(b);
          end
          if (good) exp_q.push_back(s);
        end
      end
    end
  endtask

  task automatic wait_outputs(input int exp_disc);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || ndisc < exp_disc) begin
      idle_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timed out waiting for samples or the discovery pulse");
        stop_run();
      end
    end
    repeat (4) idle_cycle();  // covers the three cycle register latency
  endtask

  initial begin
    int                        fd;
    int                        nrec;
    int                        nf;
    string                     line;
    int                        kind;
    logic [15:0]               port;
    logic                      bcast;
    logic [7:0]                arg;
    logic                      e_mox;
    logic [1:0]                e_rate;
    logic [2:0]                e_nrx;
    logic [31:0]               e_tx;
    logic [31:0]               e_rx1;
    logic                      e_run;
    logic                      e_ws;
    int                        e_disc;
    int                        e_nsamp;
    int                        e_nsync;
    radio_cfg_pkg::radio_cfg_t exp_cfg;

    seed            = 93;
    nrec            = 0;
    rst_n           = 1'b0;
    eth_port        = '0;
    eth_broadcast   = 1'b0;
    eth_valid       = 1'b0;
    eth_data        = '0;
    eth_unreachable = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check({71'h0, run}, 72'h0, "run after reset");
    check({71'h0, wide_spectrum}, 72'h0, "wide_spectrum after reset");
    check({71'h0, metis_discovery}, 72'h0, "metis_discovery after reset");
    check({71'h0, sync_err}, 72'h0, "sync_err after reset");
    check({71'h0, i_dut.cc_valid}, 72'h0, "cc_valid after reset");
    check({71'h0, sample_valid}, 72'h0, "sample_valid after reset");
    check({2'h0, cfg}, 72'h0, "cfg after reset");

    fd = $fopen("dv/ds_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file dv/ds_patterns.txt");
      stop_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 4 || line[0] == "#") continue;
      nf = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   kind, port, bcast, arg, cc_bytes[0], cc_bytes[1], cc_bytes[2], cc_bytes[3],
                   cc_bytes[4], cc_bytes[5], cc_bytes[6], cc_bytes[7], cc_bytes[8], cc_bytes[9],
                   e_mox, e_rate, e_nrx, e_tx, e_rx1, e_run, e_ws, e_disc, e_nsamp, e_nsync);
      if (nf != 24) begin
        $display("pattern record %0d has %0d fields instead of 24", nrec, nf);
        stop_run();
      end
      nsamp = 0;
      nsync = 0;
      ndisc = 0;
      if (kind == 4) begin
        build_packet(0, 8'h03);  // both run bits set first so that the clear can be seen
        stream_packet(port, 1'b0);
        wait_outputs(0);
        check({71'h0, run}, 72'h1, "run before unreachable");
        check({71'h0, wide_spectrum}, 72'h1, "wide_spectrum before unreachable");
        pulse_unreachable();
      end else begin
        build_packet(kind, arg);
        stream_packet(port, bcast);
      end
      wait_outputs(e_disc);
      exp_cfg.mox      = e_mox;
      exp_cfg.rate     = e_rate;
      exp_cfg.nrx      = e_nrx;
      exp_cfg.tx_freq  = e_tx;
      exp_cfg.rx1_freq = e_rx1;
      check({71'h0, run}, {71'h0, e_run}, "run");
      check({71'h0, wide_spectrum}, {71'h0, e_ws}, "wide_spectrum");
      check({2'h0, cfg}, {2'h0, exp_cfg}, "cfg");
      check({40'h0, ndisc}, {40'h0, e_disc}, "discovery pulse count");
      check({40'h0, nsamp}, {40'h0, e_nsamp}, "sample count");
      check({40'h0, nsync}, {40'h0, e_nsync}, "sync error count");
      nrec++;
    end
    $fclose(fd);
    if (nrec == 0) begin
      $display("the pattern file held no records");
      stop_run();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dv/ds_patterns.txt ====
# all hex: kind port bcast arg | c0..c4 block0 | c0..c4 block1 | mox rate nrx tx_freq rx1_freq
# then run ws disc nsamp nsync; kind 0 runstop 1 discovery 2 data 3 bad sync 4 unreachable
0 0400 0 03 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 1 1 0 00 0
0 0401 0 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 1 1 0 00 0
0 0400 0 01 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 1 0 0 00 0
4 0400 0 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 0 0 0 00 0
0 0400 0 02 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 0 1 0 00 0
1 0400 1 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 0 1 1 00 0
1 0400 0 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00000000 00000000 0 1 0 00 0
2 0400 0 02 00 03 00 00 28 03 01 23 45 67 1 3 5 01234567 00000000 0 1 0 7e 0
2 0400 0 02 04 89 ab cd ef 21 ff ff ff ff 1 3 5 01234567 89abcdef 0 1 0 7e 0
3 0400 0 02 02 11 11 11 11 00 01 00 00 10 0 1 2 01234567 89abcdef 0 1 0 3f 1
2 0400 0 06 00 02 00 00 38 03 55 55 55 55 0 1 2 01234567 89abcdef 0 1 0 00 0
0 0400 0 00 00 00 00 00 00 00 00 00 00 00 0 1 2 01234567 89abcdef 0 0 0 00 0

// ==== files.f ====
src/hpsdr_proto_pkg.sv
src/radio_cfg_pkg.sv
src/ds_unpacker.sv
src/frame_parser.sv
src/cc_regs.sv
src/sample_assembler.sv
src/ds_top.sv
dv/tb_ds_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the downstream receive path testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module tb_ds_top -f files.f -o tb_ds_top; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_ds_top 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
